//--- verilog.f
exec_pkg.sv
issue_buffer.sv
alu.sv
exec_unit.sv
exec_properties.sv
tb_clock_gen.sv
tb_exec.sv

//--- run.sh
#!/bin/bash
# compile and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_exec \
    -Mdir obj_dir \
    -o tb_exec_sim \
    -f verilog.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_exec_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
    echo "pass message found in sim.log"
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

//--- tb_exec.sv
`timescale 1ns/1ns

module tb_exec
    import exec_pkg::*;
();

    localparam int DEPTH         = 4;
    localparam int WAIT_LIMIT    = 200;
    localparam int RANDOM_CYCLES = 600;

    logic          clock;
    logic          rst_n;
    logic          in_valid;
    issue_packet_t in_packet;
    br_event_t     br_event;
    logic          out_ready;
    logic          in_ready;
    logic          out_valid;
    fu_packet_t    out_packet;

    // expected completions, oldest first
    fu_packet_t expected[$];
    logic       issue_fire    = 1'b0;
    logic       seen_in_ready = 1'b0;
    int         in_count      = 0;
    b_mask_t    open_mask;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    exec_unit #(
        .DEPTH(DEPTH)
    ) u_exec_unit (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_packet  (in_packet),
        .br_event   (br_event),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_packet (out_packet)
    );

    task automatic abort_test(string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string err_line(string name, logic [31:0] got, logic [31:0] exp);
        return $sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp);
    endfunction

    function automatic logic [31:0] sign_ext(logic [31:0] value, int width);
        logic [31:0] shifted;
        shifted = value << (32 - width);
        return $signed(shifted) >>> (32 - width);
    endfunction

    // expected ALU result from the RV32 operand and immediate rules
    function automatic logic [31:0] ref_alu(issue_packet_t p);
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] r;
        inst = p.inst;
        case (p.opa_sel)
            OPA_IS_RS1: a = p.rs1_value;
            OPA_IS_NPC: a = p.pc + 32'd4;
            OPA_IS_PC:  a = p.pc;
            default:    a = 32'd0;
        endcase
        case (p.opb_sel)
            OPB_IS_RS2:   b = p.rs2_value;
            OPB_IS_I_IMM: b = sign_ext({20'd0, inst[31:20]}, 12);
            OPB_IS_S_IMM: b = sign_ext({20'd0, inst[31:25], inst[11:7]}, 12);
            OPB_IS_B_IMM: b = sign_ext({19'd0, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0}, 13);
            OPB_IS_U_IMM: b = {inst[31:12], 12'd0};
            OPB_IS_J_IMM: b = sign_ext({11'd0, inst[31], inst[19:12], inst[20],
                                        inst[30:21], 1'b0}, 21);
            default:      b = 32'd0;
        endcase
        sh = b[4:0];
        case (p.alu_func)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            // flipping the sign bits turns a signed compare into an unsigned one
            ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            default:  r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic issue_packet_t random_packet(b_mask_t allowed);
        issue_packet_t p;
        p.pc        = $urandom & 32'hffff_fffc;
        p.inst      = $urandom;
        p.rs1_value = $urandom;
        p.rs2_value = $urandom;
        p.opa_sel   = opa_sel_e'(2'($urandom_range(3, 0)));
        p.opb_sel   = opb_sel_e'(3'($urandom_range(5, 0)));
        p.alu_func  = alu_func_e'(4'($urandom_range(9, 0)));
        p.dest_tag  = tag_t'($urandom);
        p.b_mask    = b_mask_t'($urandom) & allowed;
        return p;
    endfunction

    // reference model and compare, sampled between edges
    always @(negedge clock) begin
        fu_packet_t front;
        fu_packet_t item;
        fu_packet_t kept[$];
        if (rst_n) begin
            if (out_valid && out_ready) begin
                assert (expected.size() != 0)
                    else abort_test("a result came out with no item outstanding");
                front = expected.pop_front();
                assert (out_packet.result == front.result)
                    else abort_test(err_line("out_packet.result", out_packet.result,
                                             front.result));
                assert (out_packet.dest_tag == front.dest_tag)
                    else abort_test(err_line("out_packet.dest_tag", 32'(out_packet.dest_tag),
                                             32'(front.dest_tag)));
                assert (out_packet.b_mask == front.b_mask)
                    else abort_test(err_line("out_packet.b_mask", 32'(out_packet.b_mask),
                                             32'(front.b_mask)));
            end
            issue_fire    = in_valid && in_ready;
            seen_in_ready = in_ready;
            if (issue_fire) begin
                item.result   = ref_alu(in_packet);
                item.dest_tag = in_packet.dest_tag;
                item.b_mask   = in_packet.b_mask;
                expected.push_back(item);
                in_count++;
            end
            // events act after this edge's transfers
            if (br_event.kind == BR_CLEAR) begin
                foreach (expected[i]) begin
                    item = expected[i];
                    item.b_mask = item.b_mask & ~br_event.id;
                    expected[i] = item;
                end
            end else if (br_event.kind == BR_SQUASH) begin
                kept.delete();
                foreach (expected[i]) begin
                    if ((expected[i].b_mask & br_event.id) == '0) begin
                        kept.push_back(expected[i]);
                    end
                end
                expected = kept;
            end
        end
    end

    task automatic send_packet(issue_packet_t pkt);
        int tries;
        in_valid  <= 1'b1;
        in_packet <= pkt;
        tries = 0;
        do begin
            @(posedge clock);
            tries++;
        end while (!issue_fire && tries < WAIT_LIMIT);
        if (!issue_fire) begin
            abort_test("timeout waiting for the issue side to accept a micro-op");
        end
    endtask

    task automatic drain_all();
        int tries;
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        br_event  <= '0;
        tries = 0;
        while (expected.size() != 0 && tries < WAIT_LIMIT) begin
            @(posedge clock);
            tries++;
        end
        if (expected.size() != 0) begin
            abort_test("timeout while draining the outstanding items");
        end
        // idle edges so a stray completion would show up
        repeat (4) @(posedge clock);
    endtask

    initial begin
        issue_packet_t pkt;
        br_event_t     ev;
        b_mask_t       cand;
        int            tries;
        int            start_count;
        int            first_bit;
        void'($urandom(32'h21112006));
        in_valid  = 1'b0;
        in_packet = '0;
        br_event  = '0;
        out_ready = 1'b0;
        open_mask = '1;

        tries = 0;
        while (rst_n !== 1'b1 && tries < WAIT_LIMIT) begin
            @(posedge clock);
            tries++;
        end
        if (rst_n !== 1'b1) begin
            abort_test("reset was never released");
        end
        @(posedge clock);

        // every operand select and function pairing at full rate
        out_ready <= 1'b1;
        for (int a = 0; a < 4; a++) begin
            for (int b = 0; b < 6; b++) begin
                for (int f = 0; f < 10; f++) begin
                    pkt = random_packet(open_mask);
                    pkt.opa_sel  = opa_sel_e'(2'(a));
                    pkt.opb_sel  = opb_sel_e'(3'(b));
                    pkt.alu_func = alu_func_e'(4'(f));
                    send_packet(pkt);
                end
            end
        end
        drain_all();

        // random traffic, first at full throughput, then with stalls and branch events
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            @(posedge clock);
            if ($urandom_range(3, 0) == 0) begin
                open_mask = open_mask | (b_mask_t'(1) << $urandom_range(3, 0));
            end
            in_valid  <= (c < 100) || ($urandom_range(3, 0) != 0);
            in_packet <= random_packet(open_mask);
            out_ready <= (c < 200) || ($urandom_range(1, 0) == 1);
            ev = '0;
            if (c >= 200 && open_mask != '0 && $urandom_range(5, 0) == 0) begin
                first_bit = $urandom_range(3, 0);
                for (int k = 0; k < BR_COUNT; k++) begin
                    cand = b_mask_t'(1) << ((first_bit + k) % BR_COUNT);
                    if (ev.kind == BR_NONE && (open_mask & cand) != '0) begin
                        ev.kind = ($urandom_range(1, 0) == 1) ? BR_CLEAR : BR_SQUASH;
                        ev.id   = cand;
                    end
                end
                open_mask = open_mask & ~ev.id;
            end
            br_event <= ev;
        end
        drain_all();

        // fill with out_ready low until in_ready falls
        open_mask = '1;
        out_ready <= 1'b0;
        start_count = in_count;
        pkt = random_packet(open_mask);
        // oldest item ends up in the ALU register and dies on the squash below
        pkt.b_mask = pkt.b_mask | 4'b0010;
        in_valid  <= 1'b1;
        in_packet <= pkt;
        tries = 0;
        do begin
            @(posedge clock);
            tries++;
            if (issue_fire) begin
                in_packet <= random_packet(open_mask);
            end
        end while (seen_in_ready && tries < WAIT_LIMIT);
        if (seen_in_ready) begin
            abort_test("in_ready never fell while out_ready was held low");
        end
        assert (in_count - start_count == DEPTH + 1)
            else abort_test(err_line("accepted items", 32'(in_count - start_count),
                                     32'(DEPTH + 1)));
        repeat (6) begin
            @(posedge clock);
            assert (!seen_in_ready && in_count - start_count == DEPTH + 1)
                else abort_test("an issue was accepted while the buffer was full");
        end

        // clear one branch, then squash another while everything is held
        in_valid <= 1'b0;
        ev.kind = BR_CLEAR;
        ev.id   = 4'b0001;
        br_event <= ev;
        @(posedge clock);
        ev.kind = BR_SQUASH;
        ev.id   = 4'b0010;
        br_event <= ev;
        @(posedge clock);
        br_event <= '0;
        open_mask = open_mask & ~4'b0011;
        drain_all();

        if (expected.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_test("items were still expected at the end of the run");
        end
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // reset held low for the first cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

//--- exec_properties.sv
`timescale 1ns/1ns

module exec_properties import exec_pkg::*; (
    input logic       clock,
    input logic       rst_n,
    input logic       in_ready,
    input logic       out_valid,
    input logic       out_ready,
    input fu_packet_t out_packet,
    input br_event_t  br_event
);

    // result and tag hold while the consumer stalls
    a_hold_payload: assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (!out_valid ||
            (out_packet.result == $past(out_packet.result) &&
             out_packet.dest_tag == $past(out_packet.dest_tag))))
        else $error("out_packet result or dest_tag changed under back-pressure");

    // only a squash may drop a stalled result
    a_hold_valid: assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid || $past(br_event.kind) == BR_SQUASH))
        else $error("out_valid dropped under back-pressure without a squash");

    // only a clear may change a stalled mask
    a_hold_mask: assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
            (out_packet.b_mask == $past(out_packet.b_mask) ||
             $past(br_event.kind) == BR_CLEAR))
        else $error("out_packet b_mask changed under back-pressure without a clear");

    a_ready_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> in_ready)
        else $error("in_ready low right after reset");

    a_valid_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown(out_valid))
        else $error("out_valid is unknown");

endmodule

bind exec_unit exec_properties u_exec_properties (
    .clock      (clock),
    .rst_n      (rst_n),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_packet (out_packet),
    .br_event   (br_event)
);

//--- exec_unit.sv
`timescale 1ns/1ns

module exec_unit import exec_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          in_valid,
    input  issue_packet_t in_packet,
    input  br_event_t     br_event,
    input  logic          out_ready,
    output logic          in_ready,
    output logic          out_valid,
    output fu_packet_t    out_packet
);

    // buffer head to ALU
    logic          head_valid;
    logic          head_ready;
    issue_packet_t head_packet;

    issue_buffer #(
        .DEPTH(DEPTH)
    ) u_issue_buffer (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_packet   (in_packet),
        .br_event    (br_event),
        .head_ready  (head_ready),
        .in_ready    (in_ready),
        .head_valid  (head_valid),
        .head_packet (head_packet)
    );

    alu u_alu (
        .clock       (clock),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .head_packet (head_packet),
        .br_event    (br_event),
        .out_ready   (out_ready),
        .head_ready  (head_ready),
        .out_valid   (out_valid),
        .out_packet  (out_packet)
    );

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu import exec_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          head_valid,
    input  issue_packet_t head_packet,
    input  br_event_t     br_event,
    input  logic          out_ready,
    output logic          head_ready,
    output logic          out_valid,
    output fu_packet_t    out_packet
);

    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] result;
    logic [31:0] inst;

    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] u_imm;
    logic [31:0] j_imm;

    logic take;
    logic drain;

    assign inst = head_packet.inst;

    // RV32 immediates, all sign extended from bit 31
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // operand A
    always_comb begin
        case (head_packet.opa_sel)
            OPA_IS_RS1:  opa = head_packet.rs1_value;
            OPA_IS_NPC:  opa = head_packet.pc + 32'd4;
            OPA_IS_PC:   opa = head_packet.pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = '0;
        endcase
    end

    // operand B
    always_comb begin
        case (head_packet.opb_sel)
            OPB_IS_RS2:   opb = head_packet.rs2_value;
            OPB_IS_I_IMM: opb = i_imm;
            OPB_IS_S_IMM: opb = s_imm;
            OPB_IS_B_IMM: opb = b_imm;
            OPB_IS_U_IMM: opb = u_imm;
            OPB_IS_J_IMM: opb = j_imm;
            default:      opb = '0;
        endcase
    end

    // shifts only look at opb[4:0]
    always_comb begin
        case (head_packet.alu_func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLT:  result = {31'b0, $signed(opa) < $signed(opb)};
            ALU_SLTU: result = {31'b0, opa < opb};
            ALU_SLL:  result = opa << opb[4:0];
            ALU_SRL:  result = opa >> opb[4:0];
            ALU_SRA:  result = $unsigned($signed(opa) >>> opb[4:0]);
            default:  result = '0;
        endcase
    end

    // register is free when empty or emptied this cycle
    assign drain = out_valid && out_ready;
    assign head_ready = !out_valid || out_ready;

    // a head killed by this cycle's squash is popped but not kept
    assign take = head_valid && head_ready && !squash_hit(br_event, head_packet.b_mask);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (drain) begin
            out_valid <= 1'b0;
        end else if (squash_hit(br_event, out_packet.b_mask)) begin
            out_valid <= 1'b0;
        end
    end

    // result payload, held mask tracks clear events
    always_ff @(posedge clock) begin
        if (take) begin
            out_packet.result   <= result;
            out_packet.dest_tag <= head_packet.dest_tag;
            out_packet.b_mask   <= apply_clear(br_event, head_packet.b_mask);
        end else begin
            out_packet.b_mask <= apply_clear(br_event, out_packet.b_mask);
        end
    end

endmodule

//--- issue_buffer.sv
`timescale 1ns/1ns

module issue_buffer import exec_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          in_valid,
    input  issue_packet_t in_packet,
    input  br_event_t     br_event,
    input  logic          head_ready,
    output logic          in_ready,
    output logic          head_valid,
    output issue_packet_t head_packet
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    issue_packet_t mem [DEPTH];
    logic [DEPTH-1:0] entry_valid;

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;
    logic head_dead;
    logic [PTR_W-1:0] rd_ptr_inc;
    logic [PTR_W-1:0] wr_ptr_inc;

    // full means every slot is taken, live or dead
    assign in_ready = (count != CNT_W'(DEPTH));
    assign push = in_valid && in_ready;

    // a squashed entry at the head is dropped without being offered
    assign head_dead = (count != '0) && !entry_valid[rd_ptr];
    assign head_valid = (count != '0) && entry_valid[rd_ptr];
    assign head_packet = mem[rd_ptr];

    assign pop = (head_valid && head_ready) || head_dead;

    assign rd_ptr_inc = (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    assign wr_ptr_inc = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_inc;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // live bits, killed in place by a squash
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (squash_hit(br_event, mem[i].b_mask)) begin
                    entry_valid[i] <= 1'b0;
                end
            end
            if (pop) begin
                entry_valid[rd_ptr] <= 1'b0;
            end
            // an incoming item can be killed by the same event
            if (push) begin
                entry_valid[wr_ptr] <= !squash_hit(br_event, in_packet.b_mask);
            end
        end
    end

    // payload storage, masks follow clear events
    always_ff @(posedge clock) begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i].b_mask <= apply_clear(br_event, mem[i].b_mask);
        end
        if (push) begin
            mem[wr_ptr] <= in_packet;
            mem[wr_ptr].b_mask <= apply_clear(br_event, in_packet.b_mask);
        end
    end

endmodule

//--- exec_pkg.sv
package exec_pkg;

    // number of branches that can be unresolved at once
    parameter int BR_COUNT = 4;

    // one bit per unresolved branch
    typedef logic [BR_COUNT-1:0] b_mask_t;

    // physical destination register tag
    typedef logic [5:0] tag_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_NPC  = 2'd1,
        OPA_IS_PC   = 2'd2,
        OPA_IS_ZERO = 2'd3
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    // branch resolution kinds
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_CLEAR  = 2'd1,
        BR_SQUASH = 2'd2
    } br_task_e;

    // issued micro-op with its source values
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        opa_sel_e    opa_sel;
        opb_sel_e    opb_sel;
        alu_func_e   alu_func;
        tag_t        dest_tag;
        b_mask_t     b_mask;
    } issue_packet_t;

    // completion packet for writeback
    typedef struct packed {
        logic [31:0] result;
        tag_t        dest_tag;
        b_mask_t     b_mask;
    } fu_packet_t;

    // id is one-hot whenever kind is not BR_NONE
    typedef struct packed {
        br_task_e kind;
        b_mask_t  id;
    } br_event_t;

    // mask after a resolved branch is dropped
    function automatic b_mask_t apply_clear(br_event_t ev, b_mask_t mask);
        b_mask_t res;
        res = mask;
        if (ev.kind == BR_CLEAR) begin
            res = mask & ~ev.id;
        end
        return res;
    endfunction

    // true when a mispredict kills an item with this mask
    function automatic logic squash_hit(br_event_t ev, b_mask_t mask);
        return (ev.kind == BR_SQUASH) && ((mask & ev.id) != '0);
    endfunction

endpackage
